//--- src/rammodel_pkg.sv
`default_nettype none

package rammodel_pkg;

    ////////////////////
    // bus widths
    localparam int ADDR_WIDTH  = 16;
    localparam int DATA_WIDTH  = 64;
    localparam int ID_WIDTH    = 4;
    localparam int STRB_WIDTH  = DATA_WIDTH / 8;
    localparam int OFFSET_BITS = $clog2(STRB_WIDTH);    // byte offset inside a beat.

    ////////////////////
    // storage
    localparam int MEM_DEPTH = 1024;
    localparam int IDX_WIDTH = $clog2(MEM_DEPTH);

    ////////////////////
    // response timing
    localparam int DELAY_WIDTH = 5;
    localparam int R_DELAY     = 25;     // unstalled cycles, AR to R.
    localparam int W_DELAY     = 3;      // unstalled cycles, AW and W to B.

    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [DATA_WIDTH-1:0]  data_t;
    typedef logic [STRB_WIDTH-1:0]  strb_t;
    typedef logic [ID_WIDTH-1:0]    id_t;
    typedef logic [DELAY_WIDTH-1:0] delay_t;
    typedef logic [IDX_WIDTH-1:0]   word_idx_t;

endpackage

`default_nettype wire

//--- src/ready_valid_fork.sv
`timescale 1ns/1ns
`default_nettype none

module ready_valid_fork #(
    parameter int DATA_WIDTH = 8
) (
    input  wire                   clk,
    input  wire                   rst_n,

    input  wire                   in_valid,
    input  wire  [DATA_WIDTH-1:0] in_data,
    output logic                  in_ready,

    output logic                  a_valid,
    output logic [DATA_WIDTH-1:0] a_data,
    input  wire                   a_ready,

    output logic                  b_valid,
    output logic [DATA_WIDTH-1:0] b_data,
    input  wire                   b_ready
);

    logic a_taken;
    logic b_taken;

    assign a_valid  = in_valid && !a_taken;
    assign b_valid  = in_valid && !b_taken;
    assign a_data   = in_data;
    assign b_data   = in_data;
    // done once each side has taken it, now or earlier.
    assign in_ready = in_valid && (a_taken || a_ready) && (b_taken || b_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_taken <= 1'b0;
            b_taken <= 1'b0;
        end else if (in_ready) begin
            a_taken <= 1'b0;
            b_taken <= 1'b0;
        end else begin
            a_taken <= a_taken || (a_valid && a_ready);
            b_taken <= b_taken || (b_valid && b_ready);
        end
    end

    // upstream must hold the item until both sides have it.
    a_hold_payload: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

`default_nettype wire

//--- src/rammodel_timing_model.sv
`timescale 1ns/1ns
`default_nettype none

module rammodel_timing_model (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  stall,

    input  wire  arvalid,
    output logic arready,

    input  wire  awvalid,
    output logic awready,

    input  wire  wvalid,
    output logic wready,

    output logic rvalid,
    input  wire  rready,

    output logic bvalid,
    input  wire  bready
);

    logic                 r_busy;
    rammodel_pkg::delay_t r_count;

    logic                 aw_got;
    logic                 w_got;
    logic                 aw_fire;
    logic                 w_fire;
    logic                 w_start;
    rammodel_pkg::delay_t w_count;

    ////////////////////
    // read slot
    assign arready = !r_busy;
    assign rvalid  = r_busy && (r_count == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_busy  <= 1'b0;
            r_count <= '0;
        end else if (arvalid && arready) begin
            r_busy  <= 1'b1;
            r_count <= rammodel_pkg::delay_t'(rammodel_pkg::R_DELAY);
        end else if (rvalid && rready) begin
            r_busy <= 1'b0;
        end else if (r_busy && (r_count != '0) && !stall) begin
            r_count <= r_count - 1'b1;
        end
    end

    ////////////////////
    // write slot
    assign awready = !aw_got;
    assign wready  = !w_got;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign bvalid  = aw_got && w_got && (w_count == '0);

    // the later of aw and w arrives this cycle.
    assign w_start = (aw_got || aw_fire) && (w_got || w_fire) && !(aw_got && w_got);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            w_count <= '0;
        end else if (bvalid && bready) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
        end else begin
            if (aw_fire)
                aw_got <= 1'b1;
            if (w_fire)
                w_got <= 1'b1;
            if (w_start)
                w_count <= rammodel_pkg::delay_t'(rammodel_pkg::W_DELAY);
            else if (aw_got && w_got && (w_count != '0) && !stall)
                w_count <= w_count - 1'b1;     // frozen under stall.
        end
    end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid);

endmodule

`default_nettype wire

//--- src/rammodel_read_port.sv
`timescale 1ns/1ns
`default_nettype none

module rammodel_read_port (
    input  wire                     clk,
    input  wire                     rst_n,

    input  wire                     arvalid,
    input  wire rammodel_pkg::id_t  arid,
    input  wire rammodel_pkg::addr_t araddr,
    output logic                    arready,

    output logic                    rd_req,
    output rammodel_pkg::word_idx_t rd_idx,
    input  wire                     rd_gnt,
    input  wire rammodel_pkg::data_t rd_data,

    output logic                    rp_valid,
    output rammodel_pkg::id_t       rp_id,
    output rammodel_pkg::data_t     rp_data,
    input  wire                     pop
);

    logic                busy;
    logic                fresh;      // store output is the live copy.
    rammodel_pkg::data_t data_q;

    assign arready = !busy;
    assign rp_data = fresh ? rd_data : data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            rd_req   <= 1'b0;
            rp_valid <= 1'b0;
            fresh    <= 1'b0;
        end else begin
            fresh <= rd_gnt;
            if (arvalid && arready) begin
                busy   <= 1'b1;
                rd_req <= 1'b1;
            end else if (rd_gnt) begin
                rd_req   <= 1'b0;
                rp_valid <= 1'b1;
            end else if (rp_valid && pop) begin
                busy     <= 1'b0;
                rp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rd_idx <= rammodel_pkg::word_idx_t'(araddr >> rammodel_pkg::OFFSET_BITS);
            rp_id  <= arid;
        end
        if (fresh)
            data_q <= rd_data;
    end

endmodule

`default_nettype wire

//--- src/rammodel_write_port.sv
`timescale 1ns/1ns
`default_nettype none

module rammodel_write_port (
    input  wire                      clk,
    input  wire                      rst_n,

    input  wire                      awvalid,
    input  wire rammodel_pkg::id_t   awid,
    input  wire rammodel_pkg::addr_t awaddr,
    output logic                     awready,

    input  wire                      wvalid,
    input  wire rammodel_pkg::data_t wdata,
    input  wire rammodel_pkg::strb_t wstrb,
    output logic                     wready,

    output logic                     wr_req,
    output rammodel_pkg::word_idx_t  wr_idx,
    output rammodel_pkg::data_t      wr_data,
    output rammodel_pkg::strb_t      wr_strb,
    input  wire                      wr_gnt,

    output logic                     wp_valid,
    output rammodel_pkg::id_t        wp_id,
    input  wire                      pop
);

    typedef enum logic [2:0] {
        st_idle,
        st_have_addr,
        st_have_data,
        st_storing,
        st_done
    } state_t;

    state_t state;
    logic   aw_fire;
    logic   w_fire;

    assign awready  = (state == st_idle) || (state == st_have_data);
    assign wready   = (state == st_idle) || (state == st_have_addr);
    assign aw_fire  = awvalid && awready;
    assign w_fire   = wvalid && wready;
    assign wr_req   = (state == st_storing);
    assign wp_valid = (state == st_done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (aw_fire && w_fire)
                        state <= st_storing;
                    else if (aw_fire)
                        state <= st_have_addr;
                    else if (w_fire)
                        state <= st_have_data;
                end
                st_have_addr: if (w_fire) state <= st_storing;
                st_have_data: if (aw_fire) state <= st_storing;
                st_storing:   if (wr_gnt) state <= st_done;    // stored on this edge.
                st_done:      if (pop) state <= st_idle;
                default:      state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_idx <= rammodel_pkg::word_idx_t'(awaddr >> rammodel_pkg::OFFSET_BITS);
            wp_id  <= awid;
        end
        if (w_fire) begin
            wr_data <= wdata;
            wr_strb <= wstrb;
        end
    end

endmodule

`default_nettype wire

//--- src/rammodel_backing_store.sv
`timescale 1ns/1ns
`default_nettype none

module rammodel_backing_store (
    input  wire                          clk,
    input  wire                          rst_n,

    input  wire                          rd_req,
    input  wire rammodel_pkg::word_idx_t rd_idx,
    output logic                         rd_gnt,
    output rammodel_pkg::data_t          rd_data,

    input  wire                          wr_req,
    input  wire rammodel_pkg::word_idx_t wr_idx,
    input  wire rammodel_pkg::data_t     wr_data,
    input  wire rammodel_pkg::strb_t     wr_strb,
    output logic                         wr_gnt
);

    typedef enum logic {
        last_rd,
        last_wr
    } last_t;

    last_t               last_gnt;
    rammodel_pkg::data_t mem [rammodel_pkg::MEM_DEPTH];

    ////////////////////
    // arbiter
    assign rd_gnt = rd_req && (!wr_req || (last_gnt == last_wr));
    assign wr_gnt = wr_req && (!rd_req || (last_gnt == last_rd));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            last_gnt <= last_wr;    // read wins the first tie.
        else if (rd_gnt)
            last_gnt <= last_rd;
        else if (wr_gnt)
            last_gnt <= last_wr;
    end

    ////////////////////
    // storage
    initial begin
        for (int i = 0; i < rammodel_pkg::MEM_DEPTH; i++)
            mem[i] = '0;
    end

    always_ff @(posedge clk) begin
        if (wr_gnt) begin
            for (int b = 0; b < rammodel_pkg::STRB_WIDTH; b++) begin
                if (wr_strb[b])
                    mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
        if (rd_gnt)
            rd_data <= mem[rd_idx];     // held until the next read grant.
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_gnt && wr_gnt));

endmodule

`default_nettype wire

//--- src/rammodel_simple.sv
`timescale 1ns/1ns
`default_nettype none

module rammodel_simple (
    input  wire                      clk,
    input  wire                      rst_n,

    input  wire                      s_arvalid,
    input  wire rammodel_pkg::id_t   s_arid,
    input  wire rammodel_pkg::addr_t s_araddr,
    output logic                     s_arready,

    output logic                     s_rvalid,
    output rammodel_pkg::id_t        s_rid,
    output rammodel_pkg::data_t      s_rdata,
    input  wire                      s_rready,

    input  wire                      s_awvalid,
    input  wire rammodel_pkg::id_t   s_awid,
    input  wire rammodel_pkg::addr_t s_awaddr,
    output logic                     s_awready,

    input  wire                      s_wvalid,
    input  wire rammodel_pkg::data_t s_wdata,
    input  wire rammodel_pkg::strb_t s_wstrb,
    output logic                     s_wready,

    output logic                     s_bvalid,
    output rammodel_pkg::id_t        s_bid,
    input  wire                      s_bready,

    input  wire                      stall,
    output logic                     stall_gen
);

    logic tm_arvalid, tm_arready, tm_awvalid, tm_awready;
    logic tm_wvalid, tm_wready, tm_rvalid, tm_bvalid;

    logic dp_arvalid, dp_arready, dp_awvalid, dp_awready, dp_wvalid, dp_wready;
    logic [rammodel_pkg::ID_WIDTH+rammodel_pkg::ADDR_WIDTH-1:0]   dp_ar;
    logic [rammodel_pkg::ID_WIDTH+rammodel_pkg::ADDR_WIDTH-1:0]   dp_aw;
    logic [rammodel_pkg::STRB_WIDTH+rammodel_pkg::DATA_WIDTH-1:0] dp_w;

    logic                    rp_valid, wp_valid, r_fire, b_fire;
    logic                    rd_req, rd_gnt, wr_req, wr_gnt;
    rammodel_pkg::word_idx_t rd_idx, wr_idx;
    rammodel_pkg::data_t     rd_data, wr_data;
    rammodel_pkg::strb_t     wr_strb;

    ////////////////////
    // request forks
    ready_valid_fork #(.DATA_WIDTH($bits(dp_ar))) u_fork_ar (
        .clk(clk), .rst_n(rst_n),
        .in_valid(s_arvalid), .in_data({s_arid, s_araddr}), .in_ready(s_arready),
        .a_valid(tm_arvalid), .a_data(), .a_ready(tm_arready),
        .b_valid(dp_arvalid), .b_data(dp_ar), .b_ready(dp_arready)
    );

    ready_valid_fork #(.DATA_WIDTH($bits(dp_aw))) u_fork_aw (
        .clk(clk), .rst_n(rst_n),
        .in_valid(s_awvalid), .in_data({s_awid, s_awaddr}), .in_ready(s_awready),
        .a_valid(tm_awvalid), .a_data(), .a_ready(tm_awready),
        .b_valid(dp_awvalid), .b_data(dp_aw), .b_ready(dp_awready)
    );

    ready_valid_fork #(.DATA_WIDTH($bits(dp_w))) u_fork_w (
        .clk(clk), .rst_n(rst_n),
        .in_valid(s_wvalid), .in_data({s_wstrb, s_wdata}), .in_ready(s_wready),
        .a_valid(tm_wvalid), .a_data(), .a_ready(tm_wready),
        .b_valid(dp_wvalid), .b_data(dp_w), .b_ready(dp_wready)
    );

    rammodel_timing_model u_timing_model (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .arvalid(tm_arvalid), .arready(tm_arready),
        .awvalid(tm_awvalid), .awready(tm_awready),
        .wvalid(tm_wvalid), .wready(tm_wready),
        .rvalid(tm_rvalid), .rready(s_rready),
        .bvalid(tm_bvalid), .bready(s_bready)
    );

    ////////////////////
    // data path
    rammodel_read_port u_read_port (
        .clk(clk), .rst_n(rst_n),
        .arvalid(dp_arvalid), .arready(dp_arready),
        .arid(dp_ar[$high(dp_ar) -: rammodel_pkg::ID_WIDTH]),
        .araddr(dp_ar[rammodel_pkg::ADDR_WIDTH-1:0]),
        .rd_req(rd_req), .rd_idx(rd_idx), .rd_gnt(rd_gnt), .rd_data(rd_data),
        .rp_valid(rp_valid), .rp_id(s_rid), .rp_data(s_rdata), .pop(r_fire)
    );

    rammodel_write_port u_write_port (
        .clk(clk), .rst_n(rst_n),
        .awvalid(dp_awvalid), .awready(dp_awready),
        .awid(dp_aw[$high(dp_aw) -: rammodel_pkg::ID_WIDTH]),
        .awaddr(dp_aw[rammodel_pkg::ADDR_WIDTH-1:0]),
        .wvalid(dp_wvalid), .wready(dp_wready),
        .wdata(dp_w[rammodel_pkg::DATA_WIDTH-1:0]),
        .wstrb(dp_w[$high(dp_w) -: rammodel_pkg::STRB_WIDTH]),
        .wr_req(wr_req), .wr_idx(wr_idx), .wr_data(wr_data), .wr_strb(wr_strb),
        .wr_gnt(wr_gnt), .wp_valid(wp_valid), .wp_id(s_bid), .pop(b_fire)
    );

    rammodel_backing_store u_backing_store (
        .clk(clk), .rst_n(rst_n),
        .rd_req(rd_req), .rd_idx(rd_idx), .rd_gnt(rd_gnt), .rd_data(rd_data),
        .wr_req(wr_req), .wr_idx(wr_idx), .wr_data(wr_data), .wr_strb(wr_strb),
        .wr_gnt(wr_gnt)
    );

    ////////////////////
    // response joins
    assign s_rvalid = tm_rvalid;     // payload from the read port.
    assign s_bvalid = tm_bvalid;
    assign r_fire   = s_rvalid && s_rready;
    assign b_fire   = s_bvalid && s_bready;

    // response due but data still in flight.
    assign stall_gen = (tm_rvalid && !rp_valid) || (tm_bvalid && !wp_valid);

endmodule

`default_nettype wire

//--- tb/tb_rammodel_simple.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rammodel_simple;

    localparam int TIMEOUT = 200;    // cycles per wait loop.

    logic                clk;
    logic                rst_n;
    logic                s_arvalid, s_arready;
    rammodel_pkg::id_t   s_arid;
    rammodel_pkg::addr_t s_araddr;
    logic                s_rvalid, s_rready;
    rammodel_pkg::id_t   s_rid;
    rammodel_pkg::data_t s_rdata;
    logic                s_awvalid, s_awready;
    rammodel_pkg::id_t   s_awid;
    rammodel_pkg::addr_t s_awaddr;
    logic                s_wvalid, s_wready;
    rammodel_pkg::data_t s_wdata;
    rammodel_pkg::strb_t s_wstrb;
    logic                s_bvalid, s_bready;
    rammodel_pkg::id_t   s_bid;
    logic                stall, stall_gen;

    int                  cycle = 0;
    integer              seed = 32'ha51a;
    rammodel_pkg::data_t ref_mem [rammodel_pkg::MEM_DEPTH];

    rammodel_simple i_rammodel_simple (
        .clk(clk), .rst_n(rst_n),
        .s_arvalid(s_arvalid), .s_arid(s_arid), .s_araddr(s_araddr), .s_arready(s_arready),
        .s_rvalid(s_rvalid), .s_rid(s_rid), .s_rdata(s_rdata), .s_rready(s_rready),
        .s_awvalid(s_awvalid), .s_awid(s_awid), .s_awaddr(s_awaddr), .s_awready(s_awready),
        .s_wvalid(s_wvalid), .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wready(s_wready),
        .s_bvalid(s_bvalid), .s_bid(s_bid), .s_bready(s_bready),
        .stall(stall), .stall_gen(stall_gen)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;    // counts rising edges for the negedge samplers.

    always @(negedge clk) begin
        if (rst_n && stall_gen)
            fail_run("stall_gen went high although the delays cover the data latency");
    end

    ////////////////////
    // checks
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string test, input rammodel_pkg::data_t exp,
                              input rammodel_pkg::data_t act);
        if (act !== exp)
            fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h", test, exp, act));
    endtask

    task automatic check_id(input string test, input rammodel_pkg::id_t exp,
                            input rammodel_pkg::id_t act);
        if (act !== exp)
            fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h", test, exp, act));
    endtask

    task automatic check_cycles(input string test, input int exp, input int act);
        if (act != exp)
            fail_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d", test, exp, act));
    endtask

    // word index of a byte address with the upper bits wrapped.
    function automatic int word_index(input rammodel_pkg::addr_t addr);
        return (int'(addr) / rammodel_pkg::STRB_WIDTH) % rammodel_pkg::MEM_DEPTH;
    endfunction

    task automatic update_ref(input rammodel_pkg::addr_t addr, input rammodel_pkg::data_t data,
                              input rammodel_pkg::strb_t strb);
        int w;
        w = word_index(addr);
        for (int b = 0; b < rammodel_pkg::STRB_WIDTH; b++) begin
            if (strb[b])
                ref_mem[w][b*8 +: 8] = data[b*8 +: 8];
        end
    endtask

    ////////////////////
    // channel drivers
    task automatic send_ar(input rammodel_pkg::id_t id, input rammodel_pkg::addr_t addr,
                           output int hs);
        int t;
        t = 0;
        @(posedge clk);
        s_arvalid <= 1'b1;
        s_arid    <= id;
        s_araddr  <= addr;
        @(negedge clk);
        while (!s_arready) begin
            t++;
            if (t > TIMEOUT)
                fail_run("timeout waiting for s_arready");
            @(negedge clk);
        end
        hs = cycle + 1;
        @(posedge clk);
        s_arvalid <= 1'b0;
    endtask

    task automatic send_aw(input rammodel_pkg::id_t id, input rammodel_pkg::addr_t addr,
                           output int hs);
        int t;
        t = 0;
        @(posedge clk);
        s_awvalid <= 1'b1;
        s_awid    <= id;
        s_awaddr  <= addr;
        @(negedge clk);
        while (!s_awready) begin
            t++;
            if (t > TIMEOUT)
                fail_run("timeout waiting for s_awready");
            @(negedge clk);
        end
        hs = cycle + 1;
        @(posedge clk);
        s_awvalid <= 1'b0;
    endtask

    task automatic send_w(input rammodel_pkg::data_t data, input rammodel_pkg::strb_t strb,
                          output int hs);
        int t;
        t = 0;
        @(posedge clk);
        s_wvalid <= 1'b1;
        s_wdata  <= data;
        s_wstrb  <= strb;
        @(negedge clk);
        while (!s_wready) begin
            t++;
            if (t > TIMEOUT)
                fail_run("timeout waiting for s_wready");
            @(negedge clk);
        end
        hs = cycle + 1;
        @(posedge clk);
        s_wvalid <= 1'b0;
    endtask

    // s_rready stays low for hold cycles while the payload is checked.
    task automatic wait_r(input string test, input int hold,
                          input rammodel_pkg::data_t exp_data, input rammodel_pkg::id_t exp_id,
                          output int rise, output int xfer);
        int t;
        t = 0;
        @(negedge clk);
        while (!s_rvalid) begin
            t++;
            if (t > TIMEOUT)
                fail_run("timeout waiting for s_rvalid");
            @(negedge clk);
        end
        rise = cycle;
        check_data(test, exp_data, s_rdata);
        check_id(test, exp_id, s_rid);
        repeat (hold) begin
            @(negedge clk);
            if (!s_rvalid)
                fail_run("s_rvalid dropped before the R transfer");
            check_data(test, exp_data, s_rdata);
            check_id(test, exp_id, s_rid);
        end
        @(posedge clk);
        s_rready <= 1'b1;
        @(negedge clk);
        xfer = cycle + 1;
        @(posedge clk);
        s_rready <= 1'b0;
    endtask

    task automatic wait_b(output rammodel_pkg::id_t id, output int rise);
        int t;
        t = 0;
        @(negedge clk);
        while (!s_bvalid) begin
            t++;
            if (t > TIMEOUT)
                fail_run("timeout waiting for s_bvalid");
            @(negedge clk);
        end
        rise = cycle;
        id   = s_bid;
        @(posedge clk);
        s_bready <= 1'b1;
        @(posedge clk);
        s_bready <= 1'b0;
    endtask

    // a positive w_lag sends AW first and a negative one sends W first.
    task automatic write_beat(input string test, input rammodel_pkg::addr_t addr,
                              input rammodel_pkg::id_t id, input rammodel_pkg::data_t data,
                              input rammodel_pkg::strb_t strb, input int w_lag);
        int                hs_aw;
        int                hs_w;
        int                rise;
        rammodel_pkg::id_t bid;
        fork
            begin
                if (w_lag < 0)
                    repeat (-w_lag) @(posedge clk);
                send_aw(id, addr, hs_aw);
            end
            begin
                if (w_lag > 0)
                    repeat (w_lag) @(posedge clk);
                send_w(data, strb, hs_w);
            end
        join
        wait_b(bid, rise);
        check_id(test, id, bid);
        check_cycles(test, rammodel_pkg::W_DELAY, rise - ((hs_aw > hs_w) ? hs_aw : hs_w));
        update_ref(addr, data, strb);
    endtask

    task automatic read_beat(input string test, input rammodel_pkg::addr_t addr,
                             input rammodel_pkg::id_t id, input int hold, input int exp_lat,
                             output int xfer);
        int hs;
        int rise;
        send_ar(id, addr, hs);
        wait_r(test, hold, ref_mem[word_index(addr)], id, rise, xfer);
        check_cycles(test, exp_lat, rise - hs);
    endtask

    ////////////////////
    // tests
    task automatic write_then_read();
        rammodel_pkg::addr_t addrs [4];
        int                  xfer;
        for (int i = 0; i < 4; i++) begin
            addrs[i] = rammodel_pkg::addr_t'($random(seed)) & 16'hfff8;
            write_beat("write_then_read", addrs[i], rammodel_pkg::id_t'(i + 1),
                       {$random(seed), $random(seed)}, 8'hff, 0);
        end
        for (int i = 0; i < 4; i++)
            read_beat("write_then_read", addrs[i], rammodel_pkg::id_t'(15 - i), 0,
                      rammodel_pkg::R_DELAY, xfer);
    endtask

    task automatic byte_strobes();
        int                  xfer;
        rammodel_pkg::addr_t addr;
        write_beat("byte_strobes", 16'h0100, 4'h3, {$random(seed), $random(seed)}, 8'hff, 0);
        for (int i = 0; i < 6; i++) begin
            addr = (i % 2 == 0) ? 16'h0100 : 16'h2100;    // 0x2100 wraps onto 0x0100.
            write_beat("byte_strobes", addr, rammodel_pkg::id_t'(i),
                       {$random(seed), $random(seed)}, rammodel_pkg::strb_t'($random(seed)), 0);
        end
        read_beat("byte_strobes", 16'h0100, 4'h5, 0, rammodel_pkg::R_DELAY, xfer);
    endtask

    task automatic exact_latency();
        int xfer;
        write_beat("exact_latency", 16'h0040, 4'h1, {$random(seed), $random(seed)}, 8'hff, 0);
        write_beat("exact_latency", 16'h0048, 4'h2, {$random(seed), $random(seed)}, 8'hff, 3);
        write_beat("exact_latency", 16'h0050, 4'h3, {$random(seed), $random(seed)}, 8'hff, -4);
        read_beat("exact_latency", 16'h0050, 4'h4, 0, rammodel_pkg::R_DELAY, xfer);
    endtask

    task automatic stall_delay();
        int k;
        int xfer;
        k = 2 + int'($unsigned($random(seed)) % 8);
        fork
            read_beat("stall_delay", 16'h0040, 4'h6, 0, rammodel_pkg::R_DELAY + k, xfer);
            begin
                repeat (5) @(posedge clk);
                stall <= 1'b1;
                repeat (k) @(posedge clk);    // k edges see stall high.
                stall <= 1'b0;
            end
        join
    endtask

    task automatic overlap();
        int xfer;
        fork
            read_beat("overlap", 16'h0010, 4'h7, 0, rammodel_pkg::R_DELAY, xfer);
            begin
                repeat (4) @(posedge clk);
                write_beat("overlap", 16'h0018, 4'h8, {$random(seed), $random(seed)}, 8'hff, 0);
            end
        join
        read_beat("overlap", 16'h0018, 4'h9, 0, rammodel_pkg::R_DELAY, xfer);
    endtask

    task automatic backpressure();
        int hold;
        int xfer;
        int hs2;
        int rise2;
        int xfer2;
        hold = 3 + int'($unsigned($random(seed)) % 10);
        fork
            read_beat("backpressure", 16'h0100, 4'ha, hold, rammodel_pkg::R_DELAY, xfer);
            begin
                repeat (6) @(posedge clk);
                send_ar(4'hb, 16'h0018, hs2);
            end
        join
        // second AR goes through on the edge after the slot frees.
        check_cycles("backpressure", xfer + 1, hs2);
        wait_r("backpressure", 0, ref_mem[word_index(16'h0018)], 4'hb, rise2, xfer2);
        check_cycles("backpressure", rammodel_pkg::R_DELAY, rise2 - hs2);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        s_arvalid = 1'b0;
        s_arid    = '0;
        s_araddr  = '0;
        s_rready  = 1'b0;
        s_awvalid = 1'b0;
        s_awid    = '0;
        s_awaddr  = '0;
        s_wvalid  = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_bready  = 1'b0;
        stall     = 1'b0;
        for (int i = 0; i < rammodel_pkg::MEM_DEPTH; i++)
            ref_mem[i] = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (s_rvalid || s_bvalid || stall_gen || s_arready || s_awready || s_wready)
            fail_run("an output was high right after reset");
        write_then_read();
        byte_strobes();
        exact_latency();
        stall_delay();
        overlap();
        backpressure();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
src/rammodel_pkg.sv
src/ready_valid_fork.sv
src/rammodel_timing_model.sv
src/rammodel_read_port.sv
src/rammodel_write_port.sv
src/rammodel_backing_store.sv
src/rammodel_simple.sv
tb/tb_rammodel_simple.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rammodel_simple
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# the simulation binary exits non-zero on $fatal.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
